/* vic_pkg.sv */
package vic_pkg;

   // supported chip models
   typedef enum logic [1:0] {
      CHIP_6567R8   = 2'd0,
      CHIP_6567R56A = 2'd1,
      CHIP_6569     = 2'd2
   } chip_e;

   // last pixel of a line and last line of a frame
   typedef struct packed {
      logic [9:0] raster_x_max;
      logic [8:0] raster_y_max;
   } chip_limits_t;

   // where we are inside the current half phase of phi
   typedef struct packed {
      logic       phi;
      logic [3:0] tick;
      logic       dot;
   } phase_t;

   // beam position, cycle is x / 8
   typedef struct packed {
      logic [9:0] x;
      logic [8:0] line;
      logic [6:0] cycle;
      logic       line_start;
   } raster_pos_t;

   // 16 dot4x ticks per half phase
   localparam int TICKS_PER_HALF = 16;

   // dram strobe profile inside a half phase
   localparam logic [3:0] RAS_FALL    = 4'd2;
   localparam logic [3:0] CAS_FALL    = 4'd4;
   localparam logic [3:0] STROBE_RISE = 4'd14;
   // cpu data valid, register writes land here
   localparam logic [3:0] DATA_DAV    = 4'd13;

   // cycle numbers of the fixed bus slots
   localparam logic [6:0] REFRESH_FIRST = 7'd11;
   localparam logic [6:0] REFRESH_LAST  = 7'd15;
   localparam logic [6:0] CHAR_BA_FIRST = 7'd12;
   localparam logic [6:0] CHAR_FIRST    = 7'd15;
   localparam logic [6:0] CHAR_LAST     = 7'd54;

   // lines on which badlines may happen
   localparam logic [8:0] BADLINE_FIRST = 9'd48;
   localparam logic [8:0] BADLINE_LAST  = 9'd247;
   localparam logic [9:0] CHARS_PER_ROW = 10'd40;

   // raster size per chip
   function automatic chip_limits_t chip_limits(chip_e chip);
      chip_limits_t lim;
      case (chip)
         // 520 pixels, 263 lines
         CHIP_6567R8:   lim = '{raster_x_max: 10'd519, raster_y_max: 9'd262};
         // 512 pixels, 262 lines
         CHIP_6567R56A: lim = '{raster_x_max: 10'd511, raster_y_max: 9'd261};
         // pal, 504 pixels, 312 lines
         default:       lim = '{raster_x_max: 10'd503, raster_y_max: 9'd311};
      endcase
      return lim;
   endfunction

endpackage

/* vic_bus_pkg.sv */
package vic_bus_pkg;

   // one requester's claim on the vic memory bus
   typedef struct packed {
      logic        valid;
      logic [13:0] addr;
   } bus_req_t;

   // register offsets seen on adi
   typedef enum logic [5:0] {
      REG_CTRL1     = 6'h11,
      REG_RASTER    = 6'h12,
      REG_MEMPTR    = 6'h18,
      REG_IRQ_LATCH = 6'h19,
      REG_IRQ_EN    = 6'h1A
   } reg_addr_e;

   // raster irq bit in $19 and $1a
   localparam int IRQ_RST_BIT = 0;

   // address driven when nobody owns the slot
   localparam logic [13:0] IDLE_ADDR = 14'h3FFF;

   // upper address bits during refresh
   localparam logic [5:0] REFRESH_ROW = 6'h3F;

endpackage

/* vic_timing.sv */
`timescale 1ns/1ps

module vic_timing import vic_pkg::*; (
   input  logic   clk_dot4x,
   input  logic   rst,
   output phase_t phase_o,
   output logic   ras_o,
   output logic   cas_o
);

   logic [3:0] tick;
   logic [3:0] tick_nxt;
   logic       phi;

   // wraps by itself after 15
   assign tick_nxt = tick + 4'd1;

   // phi starts low, flips at the end of each half phase
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         tick <= 4'd0;
         phi  <= 1'b0;
      end else begin
         tick <= tick_nxt;
         if (tick == 4'(TICKS_PER_HALF - 1)) begin
            phi <= ~phi;
         end
      end
   end

   // dot clock rises every 4th tick
   assign phase_o.phi  = phi;
   assign phase_o.tick = tick;
   assign phase_o.dot  = (tick[1:0] == 2'd0);

   // strobes are registered, so decode the tick we are moving into
   // ras low on 2..13, cas low on 4..13
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ras_o <= 1'b1;
         cas_o <= 1'b1;
      end else begin
         ras_o <= !(tick_nxt >= RAS_FALL && tick_nxt < STROBE_RISE);
         cas_o <= !(tick_nxt >= CAS_FALL && tick_nxt < STROBE_RISE);
      end
   end

   // cas only drops inside the ras low window
   a_cas_inside_ras: assert property (
      @(posedge clk_dot4x) disable iff (rst)
      !cas_o |-> !ras_o
   );

endmodule

/* vic_raster.sv */
`timescale 1ns/1ps

module vic_raster import vic_pkg::*; #(
   parameter chip_e CHIP = CHIP_6569
) (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  phase_t      phase_i,
   output raster_pos_t pos_o
);

   localparam chip_limits_t LIM = chip_limits(CHIP);

   logic [9:0] raster_x;
   logic [8:0] raster_line;
   logic       line_start;
   logic       pixel_end;

   // last tick of a pixel, x moves together with the next dot strobe
   assign pixel_end = (phase_i.tick[1:0] == 2'd3);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x    <= 10'd0;
         raster_line <= 9'd0;
         line_start  <= 1'b0;
      end else begin
         line_start <= 1'b0;
         if (pixel_end) begin
            if (raster_x == LIM.raster_x_max) begin
               raster_x   <= 10'd0;
               line_start <= 1'b1;
               // frame wrap
               if (raster_line == LIM.raster_y_max) begin
                  raster_line <= 9'd0;
               end else begin
                  raster_line <= raster_line + 9'd1;
               end
            end else begin
               raster_x <= raster_x + 10'd1;
            end
         end
      end
   end

   assign pos_o.x          = raster_x;
   assign pos_o.line       = raster_line;
   assign pos_o.cycle      = raster_x[9:3];
   assign pos_o.line_start = line_start;

   // each dot strobe from the timing block lands on a fresh pixel
   a_dot_on_new_pixel: assert property (
      @(posedge clk_dot4x) disable iff (rst)
      phase_i.dot && !$past(rst) |-> raster_x != $past(raster_x)
   );

endmodule

/* vic_registers.sv */
`timescale 1ns/1ps

module vic_registers import vic_pkg::*, vic_bus_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  phase_t      phase_i,
   input  raster_pos_t pos_i,
   input  logic        ce_i,
   input  logic        rw_i,
   input  logic [5:0]  adi_i,
   input  logic [7:0]  dbi_i,
   input  logic        aec_i,
   output logic [7:0]  dbo_o,
   output logic        vic_write_db_o,
   output logic [2:0]  yscroll_o,
   output logic        den_o,
   output logic [3:0]  vm_o,
   output logic        irq_o
);

   // $11 bits 6..0, bit 7 lives in the compare register
   logic [6:0] ctrl1;
   logic [8:0] raster_cmp;
   // $18 bits 7..1
   logic [6:0] memptr;
   logic [3:0] irq_en;
   logic       irst;
   logic       wr_commit;

   // cpu write lands at data valid of the high phase
   assign wr_commit = phase_i.phi && phase_i.tick == DATA_DAV && !ce_i && !rw_i;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl1      <= 7'd0;
         raster_cmp <= 9'd0;
         memptr     <= 7'd0;
         irq_en     <= 4'd0;
         irst       <= 1'b0;
      end else begin
         // one compare per line, at its first tick
         if (pos_i.line_start && pos_i.line == raster_cmp) begin
            irst <= 1'b1;
         end
         if (wr_commit) begin
            case (reg_addr_e'(adi_i))
               REG_CTRL1: begin
                  ctrl1         <= dbi_i[6:0];
                  raster_cmp[8] <= dbi_i[7];
               end
               REG_RASTER:    raster_cmp[7:0] <= dbi_i;
               REG_MEMPTR:    memptr          <= dbi_i[7:1];
               // write 1 to acknowledge
               REG_IRQ_LATCH: if (dbi_i[IRQ_RST_BIT]) irst <= 1'b0;
               REG_IRQ_EN:    irq_en          <= dbi_i[3:0];
               default: ;
            endcase
         end
      end
   end

   // latch only reaches the pin when enabled
   assign irq_o = irst & irq_en[IRQ_RST_BIT];

   // read mux, unused bits and holes read 1
   always_comb begin
      case (reg_addr_e'(adi_i))
         REG_CTRL1:     dbo_o = {pos_i.line[8], ctrl1};
         REG_RASTER:    dbo_o = pos_i.line[7:0];
         REG_MEMPTR:    dbo_o = {memptr, 1'b1};
         REG_IRQ_LATCH: dbo_o = {irq_o, 6'h3F, irst};
         REG_IRQ_EN:    dbo_o = {4'hF, irq_en};
         default:       dbo_o = 8'hFF;
      endcase
   end

   // cpu reads us while it owns the bus
   assign vic_write_db_o = aec_i & rw_i & ~ce_i;

   assign yscroll_o = ctrl1[2:0];
   assign den_o     = ctrl1[4];
   // $18 bits 7..4
   assign vm_o      = memptr[6:3];

   // a cpu write only lands while the cpu holds the bus
   a_write_while_cpu_owns_bus: assert property (
      @(posedge clk_dot4x) disable iff (rst)
      wr_commit |-> aec_i
   );

endmodule

/* vic_refresh.sv */
`timescale 1ns/1ps

module vic_refresh import vic_pkg::*, vic_bus_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  phase_t      phase_i,
   input  raster_pos_t pos_i,
   input  logic        grant_i,
   output bus_req_t    req_o
);

   logic [7:0] refc;
   logic       reload;

   // frame restart, cycle 1 of line 0
   assign reload = pos_i.line == 9'd0 && pos_i.cycle == 7'd1 && !phase_i.phi &&
                   phase_i.tick == 4'd0;

   // arbiter samples the old refc on the grant tick
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         refc <= 8'hFF;
      end else if (reload) begin
         refc <= 8'hFF;
      end else if (grant_i) begin
         refc <= refc - 8'd1;
      end
   end

   // five low-phase slots per line
   assign req_o.valid = !phase_i.phi && pos_i.cycle >= REFRESH_FIRST &&
                        pos_i.cycle <= REFRESH_LAST;
   assign req_o.addr  = {REFRESH_ROW, refc};

endmodule

/* vic_char_fetch.sv */
`timescale 1ns/1ps

module vic_char_fetch import vic_pkg::*, vic_bus_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  phase_t      phase_i,
   input  raster_pos_t pos_i,
   input  logic [2:0]  yscroll_i,
   input  logic        den_i,
   input  logic [3:0]  vm_i,
   input  logic        grant_i,
   output bus_req_t    req_o,
   output logic        ba_req_o
);

   logic       allow_bad_lines;
   logic       badline;
   logic [9:0] vc;
   logic [9:0] vcbase;
   logic       low_start;
   logic       in_char_cycles;

   // first tick of a low phase
   assign low_start = !phase_i.phi && phase_i.tick == 4'd0;

   assign in_char_cycles = pos_i.cycle >= CHAR_FIRST && pos_i.cycle <= CHAR_LAST;

   // badline needs den seen on line 48 and yscroll matching the row
   assign badline = allow_bad_lines && pos_i.line >= BADLINE_FIRST &&
                    pos_i.line <= BADLINE_LAST && pos_i.line[2:0] == yscroll_i;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
         vc              <= 10'd0;
         vcbase          <= 10'd0;
      end else begin
         if (pos_i.line == BADLINE_FIRST && den_i) begin
            allow_bad_lines <= 1'b1;
         end else if (pos_i.line > BADLINE_LAST) begin
            allow_bad_lines <= 1'b0;
         end
         // vc picks up the row base before the first c-access
         if (low_start && pos_i.cycle == CHAR_FIRST) begin
            vc <= vcbase;
         end else if (grant_i) begin
            vc <= vc + 10'd1;
         end
         // next text row once this one is fetched
         if (pos_i.line_start && pos_i.line == 9'd0) begin
            vcbase <= 10'd0;
         end else if (low_start && pos_i.cycle == CHAR_LAST + 7'd1 && badline) begin
            vcbase <= vcbase + CHARS_PER_ROW;
         end
      end
   end

   // ba drops three cycles ahead of the first stolen high phase
   assign ba_req_o = badline && pos_i.cycle >= CHAR_BA_FIRST && pos_i.cycle <= CHAR_LAST;

   // c-access in the high phase, video matrix base plus vc
   assign req_o.valid = badline && phase_i.phi && in_char_cycles;
   assign req_o.addr  = {vm_i, vc};

endmodule

/* vic_bus_arbiter.sv */
`timescale 1ns/1ps

module vic_bus_arbiter import vic_pkg::*, vic_bus_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  phase_t      phase_i,
   input  bus_req_t    refresh_req_i,
   input  bus_req_t    char_req_i,
   input  logic        ba_req_i,
   output logic        refresh_grant_o,
   output logic        char_grant_o,
   output logic [13:0] addr_o,
   output logic        ba_o,
   output logic        aec_o
);

   logic slot_start;
   logic ba1;
   logic ba2;
   logic ba3;
   logic high_end;

   assign slot_start = (phase_i.tick == 4'd0);

   // low phase belongs to refresh, high phase to c-access
   assign refresh_grant_o = slot_start && !phase_i.phi && refresh_req_i.valid;
   assign char_grant_o    = slot_start && phase_i.phi && char_req_i.valid;

   // address taken on the grant tick, held for the rest of the half phase
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         addr_o <= IDLE_ADDR;
      end else if (slot_start) begin
         if (refresh_grant_o) begin
            addr_o <= refresh_req_i.addr;
         end else if (char_grant_o) begin
            addr_o <= char_req_i.addr;
         end else begin
            addr_o <= IDLE_ADDR;
         end
      end
   end

   // last tick of a high phase
   assign high_end = phase_i.phi && phase_i.tick == 4'd15;

   // ba is active low toward the cpu
   // cascade counts how many high phases saw it low
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba_o <= 1'b1;
         ba1  <= 1'b1;
         ba2  <= 1'b1;
         ba3  <= 1'b1;
      end else begin
         ba_o <= !ba_req_i;
         if (high_end) begin
            ba1 <= ba_o;
            ba2 <= ba1 | ba_o;
            ba3 <= ba2 | ba_o;
         end
      end
   end

   // aec trails phi by one tick
   // withheld in the high phase after three ba-low phases
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         aec_o <= 1'b0;
      end else begin
         aec_o <= phase_i.phi & (ba_o | ba3);
      end
   end

   // refresh and char fetch never claim the same half phase
   a_requests_exclusive: assert property (
      @(posedge clk_dot4x) disable iff (rst)
      !(refresh_req_i.valid && char_req_i.valid)
   );

endmodule

/* vic_top.sv */
`timescale 1ns/1ps

module vic_top import vic_pkg::*, vic_bus_pkg::*; #(
   parameter chip_e CHIP = CHIP_6569
) (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  logic        ce_i,
   input  logic        rw_i,
   input  logic [5:0]  adi_i,
   input  logic [7:0]  dbi_i,
   output logic        clk_phi_o,
   output logic [9:0]  raster_x_o,
   output logic [8:0]  raster_line_o,
   output logic        ras_o,
   output logic        cas_o,
   output logic [13:0] addr_o,
   output logic        ba_o,
   output logic        aec_o,
   output logic        irq_o,
   output logic [7:0]  dbo_o,
   output logic        vic_write_db_o
);

   phase_t      phase;
   raster_pos_t pos;
   bus_req_t    refresh_req;
   bus_req_t    char_req;
   logic        refresh_grant;
   logic        char_grant;
   logic        ba_req;
   logic [2:0]  yscroll;
   logic        den;
   logic [3:0]  vm;

   vic_timing timing0 (
      .clk_dot4x(clk_dot4x), .rst(rst), .phase_o(phase), .ras_o(ras_o), .cas_o(cas_o)
   );

   vic_raster #(.CHIP(CHIP)) raster0 (
      .clk_dot4x(clk_dot4x), .rst(rst), .phase_i(phase), .pos_o(pos)
   );

   vic_registers regs0 (
      .clk_dot4x(clk_dot4x), .rst(rst), .phase_i(phase), .pos_i(pos),
      .ce_i(ce_i), .rw_i(rw_i), .adi_i(adi_i), .dbi_i(dbi_i), .aec_i(aec_o),
      .dbo_o(dbo_o), .vic_write_db_o(vic_write_db_o),
      .yscroll_o(yscroll), .den_o(den), .vm_o(vm), .irq_o(irq_o)
   );

   vic_refresh refresh0 (
      .clk_dot4x(clk_dot4x), .rst(rst), .phase_i(phase), .pos_i(pos),
      .grant_i(refresh_grant), .req_o(refresh_req)
   );

   vic_char_fetch char0 (
      .clk_dot4x(clk_dot4x), .rst(rst), .phase_i(phase), .pos_i(pos),
      .yscroll_i(yscroll), .den_i(den), .vm_i(vm), .grant_i(char_grant),
      .req_o(char_req), .ba_req_o(ba_req)
   );

   vic_bus_arbiter arb0 (
      .clk_dot4x(clk_dot4x), .rst(rst), .phase_i(phase),
      .refresh_req_i(refresh_req), .char_req_i(char_req), .ba_req_i(ba_req),
      .refresh_grant_o(refresh_grant), .char_grant_o(char_grant),
      .addr_o(addr_o), .ba_o(ba_o), .aec_o(aec_o)
   );

   // beam position and phi straight to the pins
   assign clk_phi_o     = phase.phi;
   assign raster_x_o    = pos.x;
   assign raster_line_o = pos.line;

endmodule

/* tb_vic_top.sv */
`timescale 1ns/1ps

module tb_vic_top import vic_pkg::*, vic_bus_pkg::*; ();

   // 6569 raster, 504 pixels of 4 ticks and 312 lines
   localparam int TICKS_LINE  = 4 * 504;
   localparam int LINES       = 312;
   localparam int TICKS_FRAME = TICKS_LINE * LINES;
   // ticks to line 60 plus one whole frame
   localparam int CYCLE_LIMIT = TICKS_LINE * 60 + TICKS_FRAME;

   logic        clk_dot4x;
   logic        rst;
   logic        ce;
   logic        rw;
   logic [5:0]  adi;
   logic [7:0]  dbi;
   logic        clk_phi;
   logic [9:0]  raster_x;
   logic [8:0]  raster_line;
   logic        ras;
   logic        cas;
   logic [13:0] addr;
   logic        ba;
   logic        aec;
   logic        irq;
   logic [7:0]  dbo;
   logic        vic_write_db;

   // model state, t counts ticks since reset went low
   int          t;
   logic        den_m;
   logic [2:0]  ys_m;
   logic [3:0]  vm_m;
   logic [31:0] lfsr;
   int          err_count;
   int          test_errs;
   int          tests_passed;
   int          tests_failed;
   int          cycles;

   vic_top #(.CHIP(CHIP_6569)) dut0 (
      .clk_dot4x(clk_dot4x), .rst(rst), .ce_i(ce), .rw_i(rw), .adi_i(adi), .dbi_i(dbi),
      .clk_phi_o(clk_phi), .raster_x_o(raster_x), .raster_line_o(raster_line),
      .ras_o(ras), .cas_o(cas), .addr_o(addr), .ba_o(ba), .aec_o(aec), .irq_o(irq),
      .dbo_o(dbo), .vic_write_db_o(vic_write_db)
   );

   initial begin
      clk_dot4x = 1'b0;
      forever #5 clk_dot4x = ~clk_dot4x;
   end

   always @(posedge clk_dot4x) begin
      if (rst) begin
         t <= 0;
      end else begin
         t <= t + 1;
      end
   end

   // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] lfsr_take(input int nbits);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < nbits; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   // beam and phase model
   function automatic int tick_of(input int k);
      return k % 16;
   endfunction

   function automatic int phi_of(input int k);
      return (k / 16) % 2;
   endfunction

   function automatic int x_of(input int k);
      return (k / 4) % 504;
   endfunction

   function automatic int line_of(input int k);
      return (k / TICKS_LINE) % LINES;
   endfunction

   function automatic int cycle_of(input int k);
      return x_of(k) / 8;
   endfunction

   function automatic logic badline_m(input int l);
      return den_m && l >= 48 && l <= 247 && (l % 8) == ys_m;
   endfunction

   // 40 characters per earlier badline of this frame
   function automatic int vcbase_m(input int l);
      int n;
      n = 0;
      for (int i = 48; i < l; i++) begin
         if (badline_m(i)) n++;
      end
      return n * 40;
   endfunction

   // five refreshes per line from ff downward, reloaded each frame
   function automatic logic [7:0] refc_m(input int l, input int slot);
      return 8'(255 - 5 * l - slot);
   endfunction

   function automatic logic [13:0] expected_addr(input int k);
      int c;
      int l;
      c = cycle_of(k);
      l = line_of(k);
      if (phi_of(k) == 0 && c >= 11 && c <= 15) begin
         return {REFRESH_ROW, refc_m(l, c - 11)};
      end
      if (phi_of(k) == 1 && badline_m(l) && c >= 15 && c <= 54) begin
         return {vm_m, 10'd0} + 14'(vcbase_m(l) + c - 15);
      end
      return IDLE_ADDR;
   endfunction

   // first tick after k whose position in the phi cycle is off
   function automatic int next_at(input int k, input int off);
      int n;
      n = k + 1;
      while (n % 32 != off) n++;
      return n;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("ERROR %s: expected %0h, actual %0h at tick %0d", name, exp, act, t);
      err_count++;
      test_errs++;
   endtask

   task automatic finish_test(input string name);
      if (test_errs == 0) begin
         $display("test %s: ok", name);
         tests_passed++;
      end else begin
         $display("test %s: %0d mismatches", name, test_errs);
         tests_failed++;
      end
      test_errs = 0;
   endtask

   // inputs change 1 ns after the rising edge
   task automatic step();
      @(posedge clk_dot4x);
      #1;
   endtask

   task automatic go_to(input int k);
      while (t < k) step();
   endtask

   // outputs are read on the falling edge
   task automatic sample();
      @(negedge clk_dot4x);
   endtask

   // holds the cpu bus for one whole high phase
   task automatic cpu_write(input logic [5:0] a, input logic [7:0] d);
      go_to(next_at(t, 16));
      ce  = 1'b0;
      rw  = 1'b0;
      adi = a;
      dbi = d;
      go_to(t + 16);
      ce = 1'b1;
      rw = 1'b1;
   endtask

   task automatic cpu_read(input logic [5:0] a, output logic [7:0] d);
      ce  = 1'b0;
      rw  = 1'b1;
      adi = a;
      sample();
      d = dbo;
      step();
      ce = 1'b1;
   endtask

   task automatic strobes_and_idle_bus();
      int stop;
      stop = t + 2 * TICKS_LINE;
      while (t < stop) begin
         step();
         sample();
         if (ras !== !(tick_of(t) >= 2 && tick_of(t) <= 13)) begin
            report_mismatch("strobes_idle/ras", !(tick_of(t) >= 2 && tick_of(t) <= 13), ras);
         end
         if (cas !== !(tick_of(t) >= 4 && tick_of(t) <= 13)) begin
            report_mismatch("strobes_idle/cas", !(tick_of(t) >= 4 && tick_of(t) <= 13), cas);
         end
         // no refresh slot and no badline yet, so the bus idles
         if (tick_of(t) == 8 && !(phi_of(t) == 0 && cycle_of(t) >= 11 && cycle_of(t) <= 15)) begin
            if (addr !== IDLE_ADDR) report_mismatch("strobes_idle/addr", IDLE_ADDR, addr);
         end
      end
      finish_test("strobes_idle");
   endtask

   task automatic register_readback();
      logic [7:0] v;
      logic [7:0] rd;
      logic [8:0] ln;
      v = 8'(lfsr_take(8));
      cpu_write(REG_IRQ_EN, v);
      cpu_read(REG_IRQ_EN, rd);
      if (rd !== {4'hF, v[3:0]}) report_mismatch("registers/irq_en", {4'hF, v[3:0]}, rd);
      v = 8'(lfsr_take(8));
      cpu_write(REG_MEMPTR, v);
      cpu_read(REG_MEMPTR, rd);
      if (rd !== {v[7:1], 1'b1}) report_mismatch("registers/memptr", {v[7:1], 1'b1}, rd);
      v = 8'(lfsr_take(8));
      cpu_write(REG_CTRL1, v);
      ln = 9'(line_of(t));
      cpu_read(REG_CTRL1, rd);
      if (rd !== {ln[8], v[6:0]}) report_mismatch("registers/ctrl1", {ln[8], v[6:0]}, rd);
      // $12 reads the beam line, not the compare value
      cpu_write(REG_RASTER, 8'(lfsr_take(8)));
      ln = 9'(line_of(t));
      cpu_read(REG_RASTER, rd);
      if (rd !== ln[7:0]) report_mismatch("registers/raster", ln[7:0], rd);
      // data bus driven only while the cpu reads in its own phase
      go_to(next_at(t, 24));
      ce  = 1'b0;
      adi = REG_RASTER;
      sample();
      if (vic_write_db !== 1'b1) report_mismatch("registers/write_db_high", 1, vic_write_db);
      go_to(next_at(t, 8));
      sample();
      if (vic_write_db !== 1'b0) report_mismatch("registers/write_db_low", 0, vic_write_db);
      step();
      ce = 1'b1;
      finish_test("registers");
   endtask

   task automatic refresh_addresses();
      int first;
      logic [13:0] exp;
      first = line_of(t) + 1;
      for (int l = first; l < first + 2; l++) begin
         for (int c = 11; c <= 15; c++) begin
            go_to(l * TICKS_LINE + c * 32 + 8);
            sample();
            exp = {REFRESH_ROW, refc_m(l, c - 11)};
            if (addr !== exp) report_mismatch("refresh/addr", exp, addr);
         end
      end
      finish_test("refresh");
   endtask

   task automatic raster_interrupt();
      int l1;
      int l2;
      logic [7:0] rd;
      l1 = line_of(t) + 2 + int'(lfsr_take(3));
      l2 = l1 + 2 + int'(lfsr_take(3));
      cpu_write(REG_IRQ_EN, 8'h00);
      cpu_write(REG_CTRL1, 8'h00);
      cpu_write(REG_RASTER, 8'(l1));
      cpu_write(REG_IRQ_LATCH, 8'h01);
      cpu_write(REG_IRQ_EN, 8'h01);
      sample();
      if (irq !== 1'b0) report_mismatch("raster_irq/idle", 0, irq);
      // latch sets one tick after the line begins
      go_to(l1 * TICKS_LINE);
      sample();
      if (irq !== 1'b0) report_mismatch("raster_irq/early", 0, irq);
      step();
      sample();
      if (irq !== 1'b1) report_mismatch("raster_irq/rise", 1, irq);
      cpu_write(REG_IRQ_LATCH, 8'h01);
      sample();
      if (irq !== 1'b0) report_mismatch("raster_irq/ack", 0, irq);
      // masked, the latch still sets but the pin stays low
      cpu_write(REG_IRQ_EN, 8'h00);
      cpu_write(REG_RASTER, 8'(l2));
      go_to(l2 * TICKS_LINE + 1);
      sample();
      if (irq !== 1'b0) report_mismatch("raster_irq/masked", 0, irq);
      step();
      cpu_read(REG_IRQ_LATCH, rd);
      if (rd !== 8'h7F) report_mismatch("raster_irq/latch", 8'h7F, rd);
      cpu_write(REG_IRQ_LATCH, 8'h01);
      finish_test("raster_irq");
   endtask

   task automatic badline_fetches();
      int k;
      int c;
      logic bad;
      logic [3:0] vm;
      logic [2:0] ys;
      vm = 4'(lfsr_take(4));
      ys = 3'(lfsr_take(3));
      cpu_write(REG_MEMPTR, {vm, 4'h0});
      cpu_write(REG_CTRL1, {3'b000, 1'b1, 1'b0, ys});
      den_m = 1'b1;
      ys_m  = ys;
      vm_m  = vm;
      if (line_of(t) >= 47) begin
         $display("ERROR badlines: display enable was set too late for line 48");
         err_count++;
         test_errs++;
      end
      for (int l = 47; l <= 63; l++) begin
         bad = badline_m(l);
         for (int h = 0; h < 126; h++) begin
            k = l * TICKS_LINE + h * 16 + 8;
            c = cycle_of(k);
            go_to(k);
            sample();
            if (ba !== !(bad && c >= 12 && c <= 54)) begin
               report_mismatch("badlines/ba", !(bad && c >= 12 && c <= 54), ba);
            end
            if (aec !== (phi_of(k) == 1 && !(bad && c >= 15 && c <= 54))) begin
               report_mismatch("badlines/aec", (phi_of(k) == 1 && !(bad && c >= 15 && c <= 54)),
                               aec);
            end
            if (addr !== expected_addr(k)) report_mismatch("badlines/addr", expected_addr(k), addr);
         end
      end
      finish_test("badlines");
   endtask

   task automatic check_position();
      if (clk_phi !== 1'(phi_of(t))) report_mismatch("raster_position/phi", phi_of(t), clk_phi);
      if (raster_x !== 10'(x_of(t))) report_mismatch("raster_position/x", x_of(t), raster_x);
      if (raster_line !== 9'(line_of(t))) begin
         report_mismatch("raster_position/line", line_of(t), raster_line);
      end
   endtask

   // random ticks around the frame wrap, plus the two ticks at the wrap
   task automatic raster_position_sweep();
      go_to(TICKS_FRAME - 2 * TICKS_LINE + int'(lfsr_take(10)));
      while (t < TICKS_FRAME - 600) begin
         sample();
         check_position();
         go_to(t + 1 + int'(lfsr_take(9)));
      end
      go_to(TICKS_FRAME - 1);
      sample();
      check_position();
      step();
      sample();
      check_position();
      while (t < TICKS_FRAME + TICKS_LINE) begin
         go_to(t + 1 + int'(lfsr_take(9)));
         sample();
         check_position();
      end
      finish_test("raster_position");
   endtask

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk_dot4x);
         cycles = cycles + 1;
      end
      $display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
   end

   initial begin
      rst          = 1'b1;
      ce           = 1'b1;
      rw           = 1'b1;
      adi          = '0;
      dbi          = '0;
      lfsr         = 32'h48cf_58ec;
      den_m        = 1'b0;
      ys_m         = '0;
      vm_m         = '0;
      err_count    = 0;
      test_errs    = 0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (4) @(posedge clk_dot4x);
      #1;
      rst = 1'b0;
      strobes_and_idle_bus();
      register_readback();
      refresh_addresses();
      raster_interrupt();
      badline_fetches();
      raster_position_sweep();
      $display("tests passed %0d, tests failed %0d, mismatches %0d",
               tests_passed, tests_failed, err_count);
      if (tests_failed == 0 && err_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
vic_pkg.sv
vic_bus_pkg.sv
vic_timing.sv
vic_raster.sv
vic_registers.sv
vic_refresh.sv
vic_char_fetch.sv
vic_bus_arbiter.sv
vic_top.sv
tb_vic_top.sv

/* Bender.yml */
package:
  name: vic_core

sources:
  - vic_pkg.sv
  - vic_bus_pkg.sv
  - vic_timing.sv
  - vic_raster.sv
  - vic_registers.sv
  - vic_refresh.sv
  - vic_char_fetch.sv
  - vic_bus_arbiter.sv
  - vic_top.sv
  - target: test
    files:
      - tb_vic_top.sv
